//--- include/rename_settings.svh
// REB_ENTRIES must be a power of two no larger than 16 while the register values are fixed
`ifndef RENAME_SETTINGS_SVH
`define RENAME_SETTINGS_SVH

// =========================================================
// Reorder buffer sizing
// =========================================================

// Number of reorder buffer entries, each one tagged by its slot index
`define REB_ENTRIES 8

// =========================================================
// Architectural register file
// =========================================================

// Number of architectural registers, register 0 reads as zero
`define ARCH_REGS 32

// Source code meaning the newest value already sits in the register file
`define SRC_REGFILE 31

`endif

//--- rtl/rename_pkg.sv
// Vector types for the rename tracker, with widths taken from the sizing macros
`include "rename_settings.svh"

package rename_pkg;

	// =========================================================
	// Register and entry numbering
	// =========================================================

	// Architectural register number as it comes out of decode
	typedef logic [$clog2(`ARCH_REGS)-1:0] reg_idx_t;

	// Reorder buffer entry number
	// The width wraps naturally, so head and tail arithmetic needs no modulo
	typedef logic [$clog2(`REB_ENTRIES)-1:0] reb_tag_t;

	// =========================================================
	// Source table contents
	// =========================================================

	// Source code of one register
	// Holds either a reorder buffer tag or SRC_REGFILE, which never collides with a tag
	typedef logic [4:0] src_t;

	// One flag per reorder buffer entry
	typedef logic [`REB_ENTRIES-1:0] reb_mask_t;

endpackage

//--- rtl/reb_table.sv
// Tags wrap modulo REB_ENTRIES, dispatch is dropped while reb_full is high and a miss overrides all
`timescale 1ns/1ps
`include "rename_settings.svh"

module reb_table import rename_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      dec0_valid,
	input  logic      dec0_rfwr,
	input  reg_idx_t  dec0_rt,
	input  reg_idx_t  dec0_rt2,
	input  logic      dec1_valid,
	input  logic      dec1_rfwr,
	input  reg_idx_t  dec1_rt,
	input  reg_idx_t  dec1_rt2,
	input  logic      commit0,
	input  logic      commit1,
	input  logic      branchmiss,
	input  reb_tag_t  miss_tag,
	output reb_tag_t  dec0_tag,
	output reb_tag_t  dec1_tag,
	output reb_tag_t  head0_tag,
	output reb_tag_t  head1_tag,
	output logic      reb_full,
	output reg_idx_t  ent_rt [0:`REB_ENTRIES-1],
	output reg_idx_t  ent_rt2 [0:`REB_ENTRIES-1],
	output reb_mask_t latest_id,
	output reb_mask_t latest_id2
);

	// Count needs one extra bit so that a completely full buffer is representable
	localparam int CNT_W = $clog2(`REB_ENTRIES) + 1;

	reb_tag_t         head;
	reb_tag_t         tail;
	logic [CNT_W-1:0] count;
	reb_mask_t        ent_valid;
	reb_mask_t        ent_rfwr;
	logic             take0;
	logic             take1;
	logic             ret0;
	logic             ret1;
	logic [1:0]       n_take;
	logic [1:0]       n_ret;
	reb_tag_t         miss_age;
	reb_tag_t         age [0:`REB_ENTRIES-1];
	reb_mask_t        keep;
	reb_mask_t        alive;
	reb_mask_t        over_rt;
	reb_mask_t        over_rt2;

	// =========================================================
	// Pointers, strobes and back-pressure
	// =========================================================

	assign dec0_tag  = tail;
	assign dec1_tag  = reb_tag_t'(tail + 1'b1);
	assign head0_tag = head;
	assign head1_tag = reb_tag_t'(head + 1'b1);

	// Full means fewer than two free entries, so a pair of slots always fits when low
	assign reb_full = (count >= CNT_W'(`REB_ENTRIES - 1));

	// Slot 1 only allocates behind slot 0, and a miss cycle allocates nothing
	assign take0 = dec0_valid & ~reb_full & ~branchmiss;
	assign take1 = take0 & dec1_valid;
	// Retirement is guarded by the valid bit so a stray pulse cannot underflow the count
	assign ret0 = commit0 & ent_valid[head0_tag] & ~branchmiss;
	assign ret1 = ret0 & commit1 & ent_valid[head1_tag];
	assign n_take = {1'b0, take0} + {1'b0, take1};
	assign n_ret  = {1'b0, ret0} + {1'b0, ret1};

	// Position of the missing branch counted from the head, zero being the oldest
	assign miss_age = reb_tag_t'(miss_tag - head);

	// =========================================================
	// Age-ordered latest-writer scan
	// =========================================================

	always_comb begin
		for (int i = 0; i < `REB_ENTRIES; i++) begin
			age[i] = reb_tag_t'(reb_tag_t'(i) - head);
			// Outside a miss every valid entry survives
			keep[i] = ~branchmiss | (age[i] <= miss_age);
			alive[i] = ent_valid[i] & ent_rfwr[i] & keep[i];
		end
	end

	// An entry loses its flag when any younger survivor writes the same register
	// Younger writers are checked through both of their target fields
	always_comb begin
		for (int i = 0; i < `REB_ENTRIES; i++) begin
			over_rt[i]  = 1'b0;
			over_rt2[i] = 1'b0;
			for (int j = 0; j < `REB_ENTRIES; j++) begin
				if (alive[j] && age[j] > age[i]) begin
					if (ent_rt[j] == ent_rt[i] || ent_rt2[j] == ent_rt[i])
						over_rt[i] = 1'b1;
					if (ent_rt[j] == ent_rt2[i] || ent_rt2[j] == ent_rt2[i])
						over_rt2[i] = 1'b1;
				end
			end
			latest_id[i]  = alive[i] & ~over_rt[i];
			latest_id2[i] = alive[i] & ~over_rt2[i];
		end
	end

	// =========================================================
	// Control state
	// =========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			head      <= '0;
			tail      <= '0;
			count     <= '0;
			ent_valid <= '0;
		end else if (branchmiss) begin
			// Everything younger than the branch is dropped and the tail follows it
			ent_valid <= ent_valid & keep;
			tail      <= reb_tag_t'(miss_tag + 1'b1);
			count     <= CNT_W'(miss_age) + 1'b1;
		end else begin
			if (ret0)
				ent_valid[head0_tag] <= 1'b0;
			if (ret1)
				ent_valid[head1_tag] <= 1'b0;
			if (take0)
				ent_valid[dec0_tag] <= 1'b1;
			if (take1)
				ent_valid[dec1_tag] <= 1'b1;
			head  <= reb_tag_t'(head + n_ret);
			tail  <= reb_tag_t'(tail + n_take);
			count <= count + CNT_W'(n_take) - CNT_W'(n_ret);
		end
	end

	// Entry payload, only meaningful where the valid bit is set
	always_ff @(posedge clk) begin
		if (take0) begin
			ent_rfwr[dec0_tag] <= dec0_rfwr;
			ent_rt[dec0_tag]   <= dec0_rt;
			ent_rt2[dec0_tag]  <= dec0_rt2;
		end
		if (take1) begin
			ent_rfwr[dec1_tag] <= dec1_rfwr;
			ent_rt[dec1_tag]   <= dec1_rt;
			ent_rt2[dec1_tag]  <= dec1_rt2;
		end
	end

endmodule

//--- rtl/regfile_src.sv
// Dispatch strobes must already be qualified against reb_full and register 0 always reads 31
`timescale 1ns/1ps
`include "rename_settings.svh"

module regfile_src import rename_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      dec0_valid,
	input  logic      dec0_rfwr,
	input  reg_idx_t  dec0_rt,
	input  reg_idx_t  dec0_rt2,
	input  reb_tag_t  dec0_tag,
	input  logic      dec1_valid,
	input  logic      dec1_rfwr,
	input  reg_idx_t  dec1_rt,
	input  reg_idx_t  dec1_rt2,
	input  reb_tag_t  dec1_tag,
	input  logic      commit0,
	input  logic      commit1,
	input  reb_tag_t  head0_tag,
	input  reb_tag_t  head1_tag,
	input  logic      branchmiss,
	input  reg_idx_t  ent_rt [0:`REB_ENTRIES-1],
	input  reg_idx_t  ent_rt2 [0:`REB_ENTRIES-1],
	input  reb_mask_t latest_id,
	input  reb_mask_t latest_id2,
	output src_t      src_of [0:`ARCH_REGS-1]
);

	src_t src_next [0:`ARCH_REGS-1];
	logic wr0;
	logic wr1;
	logic rel1;

	// A slot only renames when it writes the register file
	assign wr0 = dec0_valid & dec0_rfwr;
	assign wr1 = dec1_valid & dec1_rfwr;

	// The second head only retires together with the first
	assign rel1 = commit0 & commit1;

	// =========================================================
	// Next-state table
	// =========================================================

	// Later assignments in this block win, which gives the priority order directly
	always_comb begin
		for (int r = 0; r < `ARCH_REGS; r++)
			src_next[r] = src_of[r];

		if (branchmiss) begin
			// Rebuild from scratch
			// Registers with no surviving writer fall back to the register file
			for (int r = 0; r < `ARCH_REGS; r++)
				src_next[r] = src_t'(`SRC_REGFILE);

			// The flags are unique per register, so the scan order does not matter
			// except that rt2 follows rt inside one entry
			for (int i = 0; i < `REB_ENTRIES; i++) begin
				if (latest_id[i])
					src_next[ent_rt[i]] = src_t'(i);
				if (latest_id2[i])
					src_next[ent_rt2[i]] = src_t'(i);
			end
		end else begin
			// Commit releases first
			// Only registers still naming a retiring tag go back to the register file,
			// a register renamed by a younger entry keeps that younger tag
			for (int r = 0; r < `ARCH_REGS; r++) begin
				if (commit0 && src_of[r] == src_t'(head0_tag))
					src_next[r] = src_t'(`SRC_REGFILE);
				if (rel1 && src_of[r] == src_t'(head1_tag))
					src_next[r] = src_t'(`SRC_REGFILE);
			end

			// Dispatch writes override the releases
			// Slot 1 is younger, so it is applied after slot 0
			if (wr0) begin
				src_next[dec0_rt]  = src_t'(dec0_tag);
				src_next[dec0_rt2] = src_t'(dec0_tag);
			end
			if (wr1) begin
				src_next[dec1_rt]  = src_t'(dec1_tag);
				src_next[dec1_rt2] = src_t'(dec1_tag);
			end
		end

		// Register 0 is never renamed
		src_next[0] = src_t'(`SRC_REGFILE);
	end

	// =========================================================
	// Source table registers
	// =========================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int r = 0; r < `ARCH_REGS; r++)
				src_of[r] <= src_t'(`SRC_REGFILE);
		end else begin
			for (int r = 0; r < `ARCH_REGS; r++)
				src_of[r] <= src_next[r];
		end
	end

endmodule

//--- rtl/rename_top.sv
// Dispatch is legal only while reb_full is low and branchmiss never coincides with a commit
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_top import rename_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     dec0_valid,
	input  logic     dec0_rfwr,
	input  reg_idx_t dec0_rt,
	input  reg_idx_t dec0_rt2,
	input  logic     dec1_valid,
	input  logic     dec1_rfwr,
	input  reg_idx_t dec1_rt,
	input  reg_idx_t dec1_rt2,
	input  logic     commit0,
	input  logic     commit1,
	input  logic     branchmiss,
	input  reb_tag_t miss_tag,
	output reb_tag_t dec0_tag,
	output reb_tag_t dec1_tag,
	output logic     reb_full,
	output src_t     src_of [0:`ARCH_REGS-1]
);

	reb_tag_t  head0_tag;
	reb_tag_t  head1_tag;
	reg_idx_t  ent_rt [0:`REB_ENTRIES-1];
	reg_idx_t  ent_rt2 [0:`REB_ENTRIES-1];
	reb_mask_t latest_id;
	reb_mask_t latest_id2;
	logic      dec0_go;
	logic      dec1_go;

	// The source table sees the same accepted dispatches as the buffer
	// Slot 1 needs slot 0 beside it
	assign dec0_go = dec0_valid & ~reb_full;
	assign dec1_go = dec1_valid & dec0_go;

	// =========================================================
	// Reorder buffer bookkeeping
	// =========================================================

	reb_table u_reb_table (
		.clk        (clk),
		.rst        (rst),
		.dec0_valid (dec0_valid),
		.dec0_rfwr  (dec0_rfwr),
		.dec0_rt    (dec0_rt),
		.dec0_rt2   (dec0_rt2),
		.dec1_valid (dec1_valid),
		.dec1_rfwr  (dec1_rfwr),
		.dec1_rt    (dec1_rt),
		.dec1_rt2   (dec1_rt2),
		.commit0    (commit0),
		.commit1    (commit1),
		.branchmiss (branchmiss),
		.miss_tag   (miss_tag),
		.dec0_tag   (dec0_tag),
		.dec1_tag   (dec1_tag),
		.head0_tag  (head0_tag),
		.head1_tag  (head1_tag),
		.reb_full   (reb_full),
		.ent_rt     (ent_rt),
		.ent_rt2    (ent_rt2),
		.latest_id  (latest_id),
		.latest_id2 (latest_id2)
	);

	// =========================================================
	// Per-register source table
	// =========================================================

	regfile_src u_regfile_src (
		.clk        (clk),
		.rst        (rst),
		.dec0_valid (dec0_go),
		.dec0_rfwr  (dec0_rfwr),
		.dec0_rt    (dec0_rt),
		.dec0_rt2   (dec0_rt2),
		.dec0_tag   (dec0_tag),
		.dec1_valid (dec1_go),
		.dec1_rfwr  (dec1_rfwr),
		.dec1_rt    (dec1_rt),
		.dec1_rt2   (dec1_rt2),
		.dec1_tag   (dec1_tag),
		.commit0    (commit0),
		.commit1    (commit1),
		.head0_tag  (head0_tag),
		.head1_tag  (head1_tag),
		.branchmiss (branchmiss),
		.ent_rt     (ent_rt),
		.ent_rt2    (ent_rt2),
		.latest_id  (latest_id),
		.latest_id2 (latest_id2),
		.src_of     (src_of)
	);

endmodule

//--- tb/rename_assert.sv
// Every check is sampled on the rising edge of clk and stays disabled while rst is high
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_assert import rename_pkg::*; (
	input logic clk,
	input logic rst,
	input logic dec0_valid,
	input logic dec1_valid,
	input logic commit0,
	input logic commit1,
	input logic branchmiss,
	input logic reb_full,
	input src_t src0
);

	// Failure count, read by the testbench when it closes the run
	int fail_count = 0;

	// ============================================================
	// Protocol rules on the inputs
	// ============================================================

	// Back-pressure is a level, so no slot may dispatch while it is high
	no_dispatch_when_full: assert property (@(posedge clk) disable iff (rst)
		!((dec0_valid || dec1_valid) && reb_full))
		else begin
			fail_count++;
			$error("dispatch strobe while reb_full is high");
		end

	// A miss and a retirement never share a cycle
	no_miss_with_commit: assert property (@(posedge clk) disable iff (rst)
		!(branchmiss && (commit0 || commit1)))
		else begin
			fail_count++;
			$error("branchmiss asserted together with a commit");
		end

	// ============================================================
	// Table invariant
	// ============================================================

	reg0_in_regfile: assert property (@(posedge clk) disable iff (rst)
		src0 == src_t'(`SRC_REGFILE))
		else begin
			fail_count++;
			$error("register 0 does not point at the register file");
		end

endmodule

//--- tb/rename_checker.sv
// The model trusts that commits only name live entries and that a miss never meets a commit
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_checker import rename_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         dec0_valid,
	input  logic         dec0_rfwr,
	input  reg_idx_t     dec0_rt,
	input  reg_idx_t     dec0_rt2,
	input  logic         dec1_valid,
	input  logic         dec1_rfwr,
	input  reg_idx_t     dec1_rt,
	input  reg_idx_t     dec1_rt2,
	input  logic         commit0,
	input  logic         commit1,
	input  logic         branchmiss,
	input  reb_tag_t     miss_tag,
	input  reb_tag_t     dec0_tag,
	input  reb_tag_t     dec1_tag,
	input  logic         reb_full,
	input  src_t         src_of [0:`ARCH_REGS-1],
	input  logic         row_active,
	input  logic [127:0] row_name,
	input  reb_tag_t     exp_tag,
	input  logic         exp_full,
	output int           errors
);

	localparam int N = `REB_ENTRIES;
	localparam int R = `ARCH_REGS;
	localparam int RF = `SRC_REGFILE;

	// Model of the buffer in age order plus the expected source table
	int m_src [0:R-1];
	int e_rfwr [0:N-1];
	int e_rt [0:N-1];
	int e_rt2 [0:N-1];
	int head;
	int tail;
	int count;

	initial errors = 0;

	// ============================================================
	// Model steps
	// ============================================================

	task automatic reset_model();
		for (int r = 0; r < R; r++)
			m_src[r] = RF;
		head = 0;
		tail = 0;
		count = 0;
	endtask

	// Oldest entry leaves, and registers still waiting on it read the register file again
	task automatic retire();
		for (int r = 0; r < R; r++)
			if (m_src[r] == head)
				m_src[r] = RF;
		head = (head + 1) % N;
		count--;
	endtask

	task automatic allocate(input logic wr, input int rt, input int rt2);
		e_rfwr[tail] = wr;
		e_rt[tail] = rt;
		e_rt2[tail] = rt2;
		// rt2 is written after rt so it wins when both name the same register
		if (wr) begin
			m_src[rt] = tail;
			m_src[rt2] = tail;
		end
		tail = (tail + 1) % N;
		count++;
	endtask

	task automatic step_model();
		int age;
		int t;
		logic take0;
		logic take1;
		if (branchmiss) begin
			age = (int'(miss_tag) - head + N) % N;
			tail = (int'(miss_tag) + 1) % N;
			count = age + 1;
			// Replay survivors oldest first so the youngest writer of each register stays
			for (int r = 0; r < R; r++)
				m_src[r] = RF;
			for (int a = 0; a < count; a++) begin
				t = (head + a) % N;
				if (e_rfwr[t]) begin
					m_src[e_rt[t]] = t;
					m_src[e_rt2[t]] = t;
				end
			end
		end else begin
			// Full means fewer than two free entries
			take0 = dec0_valid && (count < N - 1);
			take1 = take0 && dec1_valid;
			if (commit0)
				retire();
			if (commit0 && commit1)
				retire();
			if (take0)
				allocate(dec0_rfwr, int'(dec0_rt), int'(dec0_rt2));
			if (take1)
				allocate(dec1_rfwr, int'(dec1_rt), int'(dec1_rt2));
		end
		m_src[0] = RF;
	endtask

	// ============================================================
	// Comparison
	// ============================================================

	task automatic compare();
		int exp_tag1;
		// Slot 1 would receive the entry right behind the one offered to slot 0
		exp_tag1 = (int'(exp_tag) + 1) % N;
		for (int r = 0; r < R; r++) begin
			if (src_of[r] !== src_t'(m_src[r])) begin
				errors++;
				$display("MISMATCH %0s: src_of[%0d] expected %0d actual %0d",
					row_name, r, m_src[r], src_of[r]);
			end
		end
		if (row_active) begin
			if (dec0_tag !== exp_tag) begin
				errors++;
				$display("MISMATCH %0s: dec0_tag expected %0d actual %0d",
					row_name, exp_tag, dec0_tag);
			end
			if (dec1_tag !== reb_tag_t'(exp_tag1)) begin
				errors++;
				$display("MISMATCH %0s: dec1_tag expected %0d actual %0d",
					row_name, exp_tag1, dec1_tag);
			end
			if (reb_full !== exp_full) begin
				errors++;
				$display("MISMATCH %0s: reb_full expected %0d actual %0d",
					row_name, exp_full, reb_full);
			end
		end
	endtask

	// Falling edge sits between the input change and the next rising edge, so all is stable
	// The model then advances to the state the next rising edge should produce
	always @(negedge clk) begin
		if (rst) begin
			reset_model();
		end else begin
			compare();
			step_model();
		end
	end

endmodule

//--- tb/rename_tb.sv
// Expected tags in the stimulus table are written for a reorder buffer of 8 entries
`timescale 1ns/1ps
`include "rename_settings.svh"

module rename_tb import rename_pkg::*; ();

	localparam int OP_IDLE = 0;
	localparam int OP_D1 = 1;
	localparam int OP_D2 = 2;
	localparam int OP_C1 = 3;
	localparam int OP_C2 = 4;
	localparam int OP_MISS = 5;
	// Marks a target register that is drawn at random
	localparam int RND = -1;

	typedef struct {
		logic [127:0] name;
		int op;
		int wr0;
		int rt0;
		int rt2_0;
		int wr1;
		int rt1;
		int rt2_1;
		int mtag;
		int exp_tag;
		int exp_full;
	} row_t;

	logic         clk = 1'b0;
	logic         rst;
	logic         dec0_valid;
	logic         dec0_rfwr;
	reg_idx_t     dec0_rt;
	reg_idx_t     dec0_rt2;
	logic         dec1_valid;
	logic         dec1_rfwr;
	reg_idx_t     dec1_rt;
	reg_idx_t     dec1_rt2;
	logic         commit0;
	logic         commit1;
	logic         branchmiss;
	reb_tag_t     miss_tag;
	reb_tag_t     dec0_tag;
	reb_tag_t     dec1_tag;
	logic         reb_full;
	src_t         src_of [0:`ARCH_REGS-1];
	logic         row_active;
	logic [127:0] row_name;
	reb_tag_t     exp_tag;
	logic         exp_full;
	int           chk_errors;
	int           seed;
	int           cycles = 0;
	int           cycle_limit = 1000;
	row_t         rows [$];

	always #2 clk = ~clk;

	rename_top dut0 (.*);

	rename_checker chk0 (.*, .errors(chk_errors));

	bind rename_top rename_assert u_assert (
		.clk        (clk),
		.rst        (rst),
		.dec0_valid (dec0_valid),
		.dec1_valid (dec1_valid),
		.commit0    (commit0),
		.commit1    (commit1),
		.branchmiss (branchmiss),
		.reb_full   (reb_full),
		.src0       (src_of[0])
	);

	// ============================================================
	// Stimulus table
	// ============================================================

	task automatic add_row(input logic [127:0] name, input int op, input int wr0, input int rt0,
		input int rt2_0, input int wr1, input int rt1, input int rt2_1, input int mtag,
		input int exp_tag, input int exp_full);
		row_t row;
		row = '{name, op, wr0, rt0, rt2_0, wr1, rt1, rt2_1, mtag, exp_tag, exp_full};
		rows.push_back(row);
	endtask

	// Expected tag and full flag describe the buffer as the row is presented
	task automatic build_table();
		add_row("reset_idle", OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 0, 0);
		// Register 6 is named by both slots, slot 1 must win
		add_row("disp_pair", OP_D2, 1, 5, 6, 1, 6, 7, 0, 0, 0);
		add_row("disp_r0", OP_D1, 1, 0, 8, 0, 0, 0, 0, 2, 0);
		add_row("disp_rand", OP_D2, 1, RND, RND, 1, RND, RND, 0, 3, 0);
		add_row("commit_one", OP_C1, 0, 0, 0, 0, 0, 0, 0, 5, 0);
		// Register 7 moves to a younger entry before its old writer retires
		add_row("rename_again", OP_D1, 1, 7, 9, 0, 0, 0, 0, 5, 0);
		add_row("commit_two", OP_C2, 0, 0, 0, 0, 0, 0, 0, 6, 0);
		add_row("fill_a", OP_D2, 1, RND, RND, 1, RND, RND, 0, 6, 0);
		add_row("fill_b", OP_D2, 1, RND, RND, 1, RND, RND, 0, 0, 0);
		add_row("full_idle", OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 2, 1);
		add_row("drain_one", OP_C1, 0, 0, 0, 0, 0, 0, 0, 2, 1);
		add_row("not_full", OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 2, 0);
		add_row("miss_mid", OP_MISS, 0, 0, 0, 0, 0, 0, 6, 2, 0);
		add_row("after_miss", OP_D1, 1, 10, 11, 0, 0, 0, 0, 7, 0);
		add_row("disp_nowr", OP_D2, 0, 12, 12, 1, 13, 13, 0, 0, 0);
		add_row("miss_head", OP_MISS, 0, 0, 0, 0, 0, 0, 4, 2, 0);
		add_row("disp_more", OP_D2, 1, RND, RND, 1, RND, RND, 0, 5, 0);
		add_row("commit_all", OP_C2, 0, 0, 0, 0, 0, 0, 0, 7, 0);
		add_row("commit_last", OP_C1, 0, 0, 0, 0, 0, 0, 0, 7, 0);
		add_row("end_idle", OP_IDLE, 0, 0, 0, 0, 0, 0, 0, 7, 0);
	endtask

	function automatic int pick(input int v);
		if (v < 0)
			return $unsigned($random(seed)) % `ARCH_REGS;
		return v;
	endfunction

	task automatic clear_inputs();
		dec0_valid = 1'b0;
		dec1_valid = 1'b0;
		commit0 = 1'b0;
		commit1 = 1'b0;
		branchmiss = 1'b0;
	endtask

	task automatic apply_row(input row_t row);
		clear_inputs();
		dec0_rfwr = row.wr0[0];
		dec0_rt = reg_idx_t'(pick(row.rt0));
		dec0_rt2 = reg_idx_t'(pick(row.rt2_0));
		dec1_rfwr = row.wr1[0];
		dec1_rt = reg_idx_t'(pick(row.rt1));
		dec1_rt2 = reg_idx_t'(pick(row.rt2_1));
		miss_tag = reb_tag_t'(row.mtag);
		row_name = row.name;
		exp_tag = reb_tag_t'(row.exp_tag);
		exp_full = row.exp_full[0];
		case (row.op)
			OP_D1: dec0_valid = 1'b1;
			OP_D2: begin
				dec0_valid = 1'b1;
				dec1_valid = 1'b1;
			end
			OP_C1: commit0 = 1'b1;
			OP_C2: begin
				commit0 = 1'b1;
				commit1 = 1'b1;
			end
			OP_MISS: branchmiss = 1'b1;
			default: ;
		endcase
	endtask

	// ============================================================
	// Run control
	// ============================================================

	task automatic finish_run(input int timed_out);
		int afails;
		afails = dut0.u_assert.fail_count;
		$display("Summary: %0d value mismatches, %0d assertion failures, %0d timeouts",
			chk_errors, afails, timed_out);
		if (chk_errors == 0 && afails == 0 && timed_out == 0)
			$display("Everything OK");
		else
			$display("Something failed");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			finish_run(1);
			$finish;
		end
	end

	initial begin
		seed = 92;
		rst = 1'b1;
		clear_inputs();
		dec0_rfwr = 1'b0;
		dec0_rt = '0;
		dec0_rt2 = '0;
		dec1_rfwr = 1'b0;
		dec1_rt = '0;
		dec1_rt2 = '0;
		miss_tag = '0;
		row_active = 1'b0;
		row_name = "reset";
		exp_tag = '0;
		exp_full = 1'b0;
		build_table();
		cycle_limit = rows.size() + 20;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		row_active = 1'b1;
		// One row per cycle, each driven just after a rising edge
		foreach (rows[i]) begin
			apply_row(rows[i]);
			@(posedge clk);
			#1;
		end
		clear_inputs();
		row_active = 1'b0;
		// Let the checker see the effect of the last row
		repeat (2) @(posedge clk);
		finish_run(0);
		$finish;
	end

endmodule

//--- rename_top.f
+incdir+include
rtl/rename_pkg.sv
rtl/reb_table.sv
rtl/regfile_src.sv
rtl/rename_top.sv
tb/rename_assert.sv
tb/rename_checker.sv
tb/rename_tb.sv

//--- Bender.yml
package:
  name: rename_tracker

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rename_pkg.sv
      - rtl/reb_table.sv
      - rtl/regfile_src.sv
      - rtl/rename_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rename_assert.sv
      - tb/rename_checker.sv
      - tb/rename_tb.sv
